// File: cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath width in bits
`define CPU_DATA_WIDTH 8

// Program address width, 64 instruction words
`define CPU_ADDR_WIDTH 6

// General purpose registers
`define CPU_REG_COUNT 4

// Instruction word width
`define CPU_INSTR_WIDTH 16

`endif

// File: arch_types_pkg.sv
`include "cpu_defs.svh"

package arch_types_pkg;

    // Operand and result of the ALU and register file
    typedef logic [`CPU_DATA_WIDTH-1:0] data_t;

    // Program memory address
    typedef logic [`CPU_ADDR_WIDTH-1:0] addr_t;

    // Instruction word
    //   [15:12] opcode
    //   [11:10] destination register
    //   [9:8]   source register
    //   [7:0]   immediate, jump target or ALU opcode
    typedef logic [`CPU_INSTR_WIDTH-1:0] instr_t;

    // Register index
    typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_sel_t;

    // ALU operations, codes 13 to 15 unused
    typedef enum logic [3:0] {
        ALU_ADD       = 4'd0,
        ALU_ADC       = 4'd1,
        ALU_SUB       = 4'd2,   // Carry set means no borrow
        ALU_SBC       = 4'd3,
        ALU_INR       = 4'd4,
        ALU_DCR       = 4'd5,
        ALU_AND       = 4'd6,
        ALU_OR        = 4'd7,
        ALU_XOR       = 4'd8,
        ALU_INV       = 4'd9,
        ALU_ROL       = 4'd10,  // Rotate through carry
        ALU_ROR       = 4'd11,
        ALU_UNDEFINED = 4'd12
    } alu_op_t;

endpackage

// File: ctrl_types_pkg.sv
package ctrl_types_pkg;

    // Instruction opcodes in bits 15..12, codes 8 to 15 act as no-op
    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_LDI = 4'd1,  // dst <= imm
        OP_ALU = 4'd2,  // dst <= dst op src
        OP_OUT = 4'd3,  // Output dst
        OP_JMP = 4'd4,
        OP_JZ  = 4'd5,  // Jump on held zero flag
        OP_JC  = 4'd6,  // Jump on held carry flag
        OP_HLT = 4'd7
    } opcode_t;

    // Control unit states
    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_FETCH  = 3'd1,
        ST_DECODE = 3'd2,
        ST_EXEC   = 3'd3,
        ST_WRITE  = 3'd4,
        ST_HALT   = 3'd5
    } cpu_state_t;

endpackage

// File: alu.sv
`timescale 1ns/1ns
`include "cpu_defs.svh"

module alu (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    alu_en,
    input  arch_types_pkg::data_t   in_one,
    input  arch_types_pkg::data_t   in_two,
    input  logic                    in_carry,
    input  arch_types_pkg::alu_op_t alu_op,
    output arch_types_pkg::data_t   latched_result,
    output logic                    zero_flag,
    output logic                    carry_flag,
    output logic                    negative_flag
);
    import arch_types_pkg::*;

    localparam int W = `CPU_DATA_WIDTH;

    logic [W:0] wide;       // Carry out in the top bit
    logic [W:0] carry_ext;  // in_carry widened for the adder
    logic [W:0] one_ext;
    data_t      comb_result;
    logic       comb_carry;

    assign carry_ext = {{W{1'b0}}, in_carry};
    assign one_ext   = {{W{1'b0}}, 1'b1};

    always_comb begin
        wide = '0;
        case (alu_op)
            ALU_ADD: wide = {1'b0, in_one} + {1'b0, in_two};
            ALU_ADC: wide = {1'b0, in_one} + {1'b0, in_two} + carry_ext;

            // Subtract as A + ~B + 1
            ALU_SUB: wide = {1'b0, in_one} + {1'b0, ~in_two} + one_ext;
            ALU_SBC: wide = {1'b0, in_one} + {1'b0, ~in_two} + carry_ext;

            ALU_INR: wide = {1'b0, in_one} + one_ext;
            ALU_DCR: wide = {1'b0, in_one} + {1'b0, {W{1'b1}}};  // Adds all ones

            // Logic ops leave carry clear
            ALU_AND: wide = {1'b0, in_one & in_two};
            ALU_OR:  wide = {1'b0, in_one | in_two};
            ALU_XOR: wide = {1'b0, in_one ^ in_two};
            ALU_INV: wide = {1'b0, ~in_one};

            // Old carry rotates in, shifted-out bit becomes the new carry
            ALU_ROL: wide = {in_one[W-1], in_one[W-2:0], in_carry};
            ALU_ROR: wide = {in_one[0], in_carry, in_one[W-1:1]};

            default: wide = '0;  // ALU_UNDEFINED and codes 13..15
        endcase
    end

    assign comb_result = wide[W-1:0];
    assign comb_carry  = wide[W];

    // Flags hold between ALU instructions for conditional jumps
    always_ff @(posedge clk) begin
        if (reset) begin
            latched_result <= '0;
            zero_flag      <= 1'b1;
            carry_flag     <= 1'b0;
            negative_flag  <= 1'b0;
        end else if (alu_en) begin
            latched_result <= comb_result;
            zero_flag      <= (comb_result == '0);
            carry_flag     <= comb_carry;       // Set means no borrow on subtract
            negative_flag  <= comb_result[W-1];
        end
    end

endmodule

// File: reg_file.sv
`timescale 1ns/1ns
`include "cpu_defs.svh"

module reg_file (
    input  logic                     clk,
    input  logic                     reset,
    input  arch_types_pkg::reg_sel_t rd_sel_a,
    input  arch_types_pkg::reg_sel_t rd_sel_b,
    input  arch_types_pkg::reg_sel_t wr_sel,
    input  logic                     wr_en,
    input  arch_types_pkg::data_t    wr_data,
    output arch_types_pkg::data_t    rd_data_a,
    output arch_types_pkg::data_t    rd_data_b
);
    import arch_types_pkg::*;

    data_t regs [`CPU_REG_COUNT];

    // Single write port
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_sel] <= wr_data;
        end
    end

    // Asynchronous reads, no bypass of a write in the same cycle
    assign rd_data_a = regs[rd_sel_a];  // Destination operand
    assign rd_data_b = regs[rd_sel_b];  // Source operand

endmodule

// File: prog_mem.sv
`timescale 1ns/1ns
`include "cpu_defs.svh"

module prog_mem (
    input  logic                   clk,
    input  logic                   load_en,
    input  arch_types_pkg::addr_t  load_addr,
    input  arch_types_pkg::instr_t load_data,
    input  arch_types_pkg::addr_t  fetch_addr,
    output arch_types_pkg::instr_t instr
);
    import arch_types_pkg::*;

    localparam int DEPTH = 2 ** `CPU_ADDR_WIDTH;

    instr_t mem [DEPTH];

    // External load port, gated by the core while running
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // Registered read, one cycle latency
    always_ff @(posedge clk) begin
        instr <= mem[fetch_addr];
    end

endmodule

// File: control_unit.sv
`timescale 1ns/1ns
`include "cpu_defs.svh"

module control_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  arch_types_pkg::instr_t   instr,
    input  logic                     zero_flag,
    input  logic                     carry_flag,
    input  arch_types_pkg::data_t    rd_data_a,
    output arch_types_pkg::addr_t    fetch_addr,
    output arch_types_pkg::reg_sel_t rd_sel_a,
    output arch_types_pkg::reg_sel_t rd_sel_b,
    output arch_types_pkg::reg_sel_t wr_sel,
    output logic                     reg_we,
    output logic                     wr_from_alu,
    output arch_types_pkg::data_t    imm,
    output logic                     alu_en,
    output arch_types_pkg::alu_op_t  alu_op,
    output logic                     out_valid,
    output arch_types_pkg::data_t    out_data,
    output logic                     busy,
    output logic                     halted,
    output logic                     load_block
);
    import arch_types_pkg::*;
    import ctrl_types_pkg::*;

    cpu_state_t state;
    cpu_state_t state_next;
    addr_t      pc;
    instr_t     ir;
    opcode_t    op;
    logic       jump_taken;

    assign op = opcode_t'(ir[15:12]);

    // Conditions use the flags held since the last ALU instruction
    always_comb begin
        case (op)
            OP_JMP:  jump_taken = 1'b1;
            OP_JZ:   jump_taken = zero_flag;
            OP_JC:   jump_taken = carry_flag;
            default: jump_taken = 1'b0;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE,
            ST_HALT:   if (start) state_next = ST_FETCH;
            ST_FETCH:  state_next = ST_DECODE;
            ST_DECODE: state_next = ST_EXEC;
            ST_EXEC: begin
                if (op == OP_ALU) begin
                    state_next = ST_WRITE;  // Result lands in WRITE
                end else if (op == OP_HLT) begin
                    state_next = ST_HALT;
                end else begin
                    state_next = ST_FETCH;
                end
            end
            ST_WRITE:  state_next = ST_FETCH;
            default:   state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            pc    <= '0;
            ir    <= '0;
        end else begin
            state <= state_next;
            case (state)
                ST_IDLE,
                ST_HALT:   if (start) pc <= '0;
                ST_FETCH:  pc <= pc + addr_t'(1);  // Wraps at 64
                ST_DECODE: ir <= instr;            // Memory output valid here
                ST_EXEC:   if (jump_taken) pc <= ir[`CPU_ADDR_WIDTH-1:0];
                default:   ;
            endcase
        end
    end

    assign fetch_addr = pc;

    // Selects come straight from memory in DECODE, from ir afterwards
    assign rd_sel_a = (state == ST_DECODE) ? instr[11:10] : ir[11:10];
    assign rd_sel_b = (state == ST_DECODE) ? instr[9:8] : ir[9:8];

    assign wr_sel      = ir[11:10];
    assign imm         = ir[`CPU_DATA_WIDTH-1:0];
    assign alu_op      = alu_op_t'(ir[3:0]);
    assign alu_en      = (state == ST_EXEC) && (op == OP_ALU);
    assign reg_we      = ((state == ST_EXEC) && (op == OP_LDI)) || (state == ST_WRITE);
    assign wr_from_alu = (state == ST_WRITE);

    assign out_valid = (state == ST_EXEC) && (op == OP_OUT);  // One-cycle pulse
    assign out_data  = rd_data_a;

    assign busy       = (state == ST_FETCH) || (state == ST_DECODE) ||
                        (state == ST_EXEC)  || (state == ST_WRITE);
    assign halted     = (state == ST_HALT);
    assign load_block = busy;

endmodule

// File: cpu_core.sv
`timescale 1ns/1ns

module cpu_core (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   load_en,
    input  arch_types_pkg::addr_t  load_addr,
    input  arch_types_pkg::instr_t load_data,
    output logic                   out_valid,
    output arch_types_pkg::data_t  out_data,
    output logic                   busy,
    output logic                   halted
);
    import arch_types_pkg::*;

    addr_t    fetch_addr;
    instr_t   instr;
    reg_sel_t rd_sel_a;
    reg_sel_t rd_sel_b;
    reg_sel_t wr_sel;
    logic     reg_we;
    logic     wr_from_alu;
    data_t    imm;
    data_t    wr_data;
    data_t    rd_data_a;
    data_t    rd_data_b;
    logic     alu_en;
    alu_op_t  alu_op;
    data_t    latched_result;
    logic     zero_flag;
    logic     carry_flag;
    logic     load_block;
    logic     mem_load;

    assign mem_load = load_en && !load_block;              // Drop loads while running
    assign wr_data  = wr_from_alu ? latched_result : imm;

    control_unit u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .instr       (instr),
        .zero_flag   (zero_flag),
        .carry_flag  (carry_flag),
        .rd_data_a   (rd_data_a),
        .fetch_addr  (fetch_addr),
        .rd_sel_a    (rd_sel_a),
        .rd_sel_b    (rd_sel_b),
        .wr_sel      (wr_sel),
        .reg_we      (reg_we),
        .wr_from_alu (wr_from_alu),
        .imm         (imm),
        .alu_en      (alu_en),
        .alu_op      (alu_op),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .busy        (busy),
        .halted      (halted),
        .load_block  (load_block)
    );

    // Carry flag loops back for ADC, SBC and rotates
    alu u_alu (
        .clk            (clk),
        .reset          (reset),
        .alu_en         (alu_en),
        .in_one         (rd_data_a),
        .in_two         (rd_data_b),
        .in_carry       (carry_flag),
        .alu_op         (alu_op),
        .latched_result (latched_result),
        .zero_flag      (zero_flag),
        .carry_flag     (carry_flag),
        .negative_flag  ()                  // No jump on sign
    );

    reg_file u_regs (
        .clk       (clk),
        .reset     (reset),
        .rd_sel_a  (rd_sel_a),
        .rd_sel_b  (rd_sel_b),
        .wr_sel    (wr_sel),
        .wr_en     (reg_we),
        .wr_data   (wr_data),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    prog_mem u_prog (
        .clk        (clk),
        .load_en    (mem_load),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .fetch_addr (fetch_addr),
        .instr      (instr)
    );

endmodule

// File: tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 10
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;  // Free running

endmodule

// File: cpu_core_tb.sv
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_core_tb;
    import arch_types_pkg::*;
    import ctrl_types_pkg::*;

    localparam int MEM_DEPTH   = 2 ** `CPU_ADDR_WIDTH;
    localparam int RUN_TIMEOUT = 500;

    logic   clk;
    logic   reset;
    logic   start;
    logic   load_en;
    addr_t  load_addr;
    instr_t load_data;
    logic   out_valid;
    data_t  out_data;
    logic   busy;
    logic   halted;

    instr_t prog_image [MEM_DEPTH];  // Program the DUT should hold
    data_t  model_regs [`CPU_REG_COUNT];
    logic   model_zero;
    logic   model_carry;
    instr_t prog_q [$];
    data_t  expected_q [$];
    data_t  got_q [$];
    int     errors;
    int     errors_at_start;
    int     checks;
    int     tests_run;
    int     tests_failed;
    int     seed;

    tb_clock u_clock (.clk(clk));

    cpu_core uut (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .busy      (busy),
        .halted    (halted)
    );

    task automatic check_data(data_t got, data_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s expected %02h got %02h", $time, what, exp, got);
        end
    endtask

    task automatic check_count(int got, int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("error at %0t ns: output count expected %0d got %0d", $time, exp, got);
        end
    endtask

    task automatic check_level(logic got, logic exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s expected %b got %b", $time, what, exp, got);
        end
    endtask

    task automatic emit(opcode_t op, reg_sel_t dst, reg_sel_t src, data_t low);
        prog_q.push_back({op, dst, src, low});
    endtask

    // Taken branch outputs r3, fall-through outputs r2
    task automatic add_branch(opcode_t cond);
        int p;
        p = prog_q.size();
        emit(cond, 2'd0, 2'd0, data_t'(p + 3));
        emit(OP_OUT, 2'd2, 2'd0, 8'h00);
        emit(OP_JMP, 2'd0, 2'd0, data_t'(p + 4));
        emit(OP_OUT, 2'd3, 2'd0, 8'h00);
    endtask

    // r0 <= a op b, optional branch on the new flags, then output r0
    task automatic op_case(alu_op_t op, data_t a, data_t b, opcode_t cond);
        emit(OP_LDI, 2'd0, 2'd0, a);
        emit(OP_LDI, 2'd1, 2'd0, b);
        emit(OP_ALU, 2'd0, 2'd1, {4'h0, op});
        if (cond != OP_NOP) begin
            add_branch(cond);
        end
        emit(OP_OUT, 2'd0, 2'd0, 8'h00);
    endtask

    task automatic new_program();
        prog_q.delete();
        emit(OP_LDI, 2'd2, 2'd0, 8'hAA);  // Branch not taken marker
        emit(OP_LDI, 2'd3, 2'd0, 8'h55);  // Branch taken marker
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        repeat (8) @(negedge clk);
        reset       = 1'b0;
        model_regs  = '{default: '0};
        model_zero  = 1'b1;
        model_carry = 1'b0;
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_q.size(); i++) begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = addr_t'(i);
            load_data = prog_q[i];
            prog_image[addr_t'(i)] = prog_q[i];
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic model_alu_step(alu_op_t op, reg_sel_t dst, reg_sel_t src);
        int    a;
        int    b;
        int    c;
        int    r;
        data_t result;
        a = int'(model_regs[dst]);
        b = int'(model_regs[src]);
        c = model_carry ? 1 : 0;
        case (op)
            ALU_ADD: r = a + b;
            ALU_ADC: r = a + b + c;
            ALU_SUB: r = a - b;
            ALU_SBC: r = a - b - (1 - c);  // Clear carry borrows one more
            ALU_INR: r = a + 1;
            ALU_DCR: r = a - 1;
            ALU_AND: r = a & b;
            ALU_OR:  r = a | b;
            ALU_XOR: r = a ^ b;
            ALU_INV: r = 255 - a;
            ALU_ROL: r = a * 2 + c;
            ALU_ROR: r = a / 2 + c * 128;
            default: r = 0;
        endcase
        case (op)
            ALU_ADD, ALU_ADC, ALU_INR: model_carry = (r > 255);
            ALU_SUB, ALU_SBC, ALU_DCR: model_carry = (r >= 0);  // No borrow
            ALU_ROL: model_carry = (a >= 128);
            ALU_ROR: model_carry = (a % 2 == 1);
            default: model_carry = 1'b0;
        endcase
        result          = data_t'(r & 255);
        model_regs[dst] = result;
        model_zero      = (result == '0);
    endtask

    // Steps the loaded program from address 0 until HLT
    task automatic predict_outputs();
        addr_t  pc;
        instr_t w;
        int     steps;
        logic   done;
        expected_q.delete();
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < RUN_TIMEOUT) begin
            w  = prog_image[pc];
            pc = pc + addr_t'(1);  // Wraps at 64
            steps++;
            case (opcode_t'(w[15:12]))
                OP_LDI:  model_regs[w[11:10]] = w[7:0];
                OP_ALU:  model_alu_step(alu_op_t'(w[3:0]), w[11:10], w[9:8]);
                OP_OUT:  expected_q.push_back(model_regs[w[11:10]]);
                OP_JMP:  pc = w[5:0];
                OP_JZ:   pc = model_zero ? w[5:0] : pc;
                OP_JC:   pc = model_carry ? w[5:0] : pc;
                OP_HLT:  done = 1'b1;
                default: ;
            endcase
        end
    endtask

    task automatic run_program(bit poke_loads);
        int   cycles;
        logic busy_held;
        got_q.delete();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start     = 1'b0;
        cycles    = 0;
        busy_held = 1'b1;
        while (!halted && cycles < RUN_TIMEOUT) begin
            if (out_valid) begin
                got_q.push_back(out_data);
            end
            busy_held = busy_held & busy;
            load_en   = poke_loads;  // HLT words over the running program
            load_addr = addr_t'(cycles);
            load_data = {OP_HLT, 12'h000};
            @(negedge clk);
            cycles++;
        end
        load_en = 1'b0;
        if (!halted) begin
            errors++;
            $display("timeout at %0t ns: processor did not halt within %0d cycles",
                     $time, RUN_TIMEOUT);
        end else begin
            check_level(busy_held, 1'b1, "busy while running");
            check_level(busy, 1'b0, "busy when halted");
        end
    endtask

    task automatic compare_run(bit poke_loads);
        predict_outputs();
        run_program(poke_loads);
        check_count(got_q.size(), expected_q.size());
        for (int i = 0; i < expected_q.size() && i < got_q.size(); i++) begin
            check_data(got_q[i], expected_q[i], $sformatf("output %0d", i));
        end
    endtask

    task automatic load_and_check();
        emit(OP_HLT, 2'd0, 2'd0, 8'h00);
        load_program();
        compare_run(1'b0);
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    task automatic test_add_carry();
        new_program();
        op_case(ALU_ADD, 8'hFF, 8'h01, OP_JC);  // Carry out of the top
        op_case(ALU_ADC, 8'h10, 8'h20, OP_JC);
        load_and_check();
        end_test("add and carry chain");
    endtask

    task automatic test_sub_borrow();
        new_program();
        op_case(ALU_SUB, 8'h50, 8'h30, OP_JC);
        op_case(ALU_SBC, 8'h10, 8'h30, OP_JC);
        op_case(ALU_SBC, 8'h30, 8'h30, OP_JC);  // Equal with borrow in
        op_case(ALU_SUB, 8'h30, 8'h30, OP_JC);
        load_and_check();
        end_test("subtract and borrow");
    endtask

    task automatic test_logic_rotate();
        new_program();
        op_case(ALU_AND, 8'hC3, 8'h5A, OP_NOP);
        op_case(ALU_OR,  8'hC3, 8'h5A, OP_NOP);
        op_case(ALU_XOR, 8'hC3, 8'h5A, OP_NOP);
        op_case(ALU_INV, 8'hC3, 8'h5A, OP_NOP);
        op_case(ALU_ADD, 8'hFF, 8'h01, OP_NOP);  // Carry set
        op_case(ALU_ROL, 8'h81, 8'h00, OP_JC);
        op_case(ALU_ROR, 8'h02, 8'h00, OP_JC);
        op_case(ALU_AND, 8'h00, 8'h00, OP_NOP);  // Carry clear
        op_case(ALU_ROL, 8'h40, 8'h00, OP_JC);
        op_case(ALU_ROR, 8'h01, 8'h00, OP_JC);
        load_and_check();
        end_test("logic and rotates");
    endtask

    task automatic test_inc_dec_zero();
        new_program();
        op_case(ALU_INR, 8'hFF, 8'h00, OP_JZ);
        op_case(ALU_DCR, 8'h01, 8'h00, OP_JZ);
        op_case(ALU_DCR, 8'h00, 8'h00, OP_JZ);
        load_and_check();
        end_test("increment, decrement and zero");
    endtask

    task automatic test_control();
        apply_reset();
        check_level(busy, 1'b0, "busy after reset");
        check_level(halted, 1'b0, "halted after reset");
        check_level(out_valid, 1'b0, "out_valid after reset");
        new_program();
        op_case(ALU_ADD, 8'h11, 8'h22, OP_NOP);
        emit(OP_HLT, 2'd0, 2'd0, 8'h00);
        emit(OP_OUT, 2'd0, 2'd0, 8'h00);  // Behind the halt
        load_program();
        compare_run(1'b1);
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_level(out_valid, 1'b0, "out_valid after halt");
        end
        check_level(halted, 1'b1, "halted held");
        compare_run(1'b0);  // Rerun of the same program from 0
        end_test("control and restart");
    endtask

    task automatic test_random();
        data_t a;
        data_t b;
        for (int n = 0; n < 20; n++) begin
            a = data_t'($random(seed));
            b = data_t'($random(seed));
            new_program();
            op_case(ALU_ADD, a, b, OP_JC);
            op_case(ALU_SUB, a, b, OP_JC);
            op_case(ALU_XOR, a, b, OP_JZ);
            load_and_check();
        end
        end_test("random operands");
    endtask

    initial begin
        reset           = 1'b1;
        start           = 1'b0;
        load_en         = 1'b0;
        load_addr       = '0;
        load_data       = '0;
        errors          = 0;
        errors_at_start = 0;
        checks          = 0;
        tests_run       = 0;
        tests_failed    = 0;
        seed            = 62235;
        apply_reset();
        test_add_carry();
        test_sub_borrow();
        test_logic_rotate();
        test_inc_dec_zero();
        test_control();
        test_random();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: cpu_core.f
+incdir+.
arch_types_pkg.sv
ctrl_types_pkg.sv
alu.sv
reg_file.sv
prog_mem.sv
control_unit.sv
cpu_core.sv
tb_clock.sv
cpu_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns --top-module cpu_core_tb -f cpu_core.f ||
    { echo "build failed"; exit 1; }

./obj_dir/Vcpu_core_tb | tee /dev/stderr | grep -qx "STATUS: PASS" &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }
